/* design/nocPkg.sv */
`default_nettype none

package nocPkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Flit format.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int LEN_W = 12;
  localparam int FLIT_DATA_W = 32;
  localparam int NUM_PORTS = 5;

  typedef enum logic [2:0] {
    FLIT_IDLE = 3'd0,
    FLIT_HEAD = 3'd1,
    FLIT_BODY = 3'd2,
    FLIT_TAIL = 3'd3
  } flitKindT;

  // The length field is only meaningful when kind is FLIT_HEAD.
  typedef struct packed {
    flitKindT               kind;
    logic [LEN_W-1:0]       length;
    logic [FLIT_DATA_W-1:0] data;
  } flitT;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Ports and grant encoding.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [2:0] {
    PORT_L = 3'd0,
    PORT_N = 3'd1,
    PORT_E = 3'd2,
    PORT_W = 3'd3,
    PORT_S = 3'd4
  } portIdxT;

  // Bit 0 is idle, bits 1 to 5 grant L, N, E, W and S.
  typedef logic [NUM_PORTS:0] grantT;

  localparam grantT GRANT_IDLE = 6'b00_0001;

  // One-hot grant state for a given port.
  function automatic grantT portGrant(input portIdxT port);
    grantT oneHot;
    oneHot = '0;
    oneHot[int'(port) + 1] = 1'b1;
    return oneHot;
  endfunction

  // The port that follows in rotation, wrapping from S back to L.
  function automatic portIdxT nextPort(input portIdxT port);
    portIdxT follow;
    if (port == PORT_S)
      follow = PORT_L;
    else
      follow = portIdxT'(int'(port) + 1);
    return follow;
  endfunction

endpackage

`default_nettype wire

/* design/packetTimer.sv */
`timescale 1ns/1ps
`default_nettype none

module packetTimer
  import nocPkg::*;
(
  input  wire logic clk,
  input  wire logic rst,
  input  wire flitT inFlit,
  input  wire logic run,
  output logic      timesUp
);

  logic [LEN_W-1:0] limit;
  logic [LEN_W-1:0] count;

  // The limit follows every head flit on this input, requesting or not.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
    end
    else if (inFlit.kind == FLIT_HEAD)
    begin
      limit <= inFlit.length;
    end
  end

  // Counting restarts at zero whenever the port is not holding the grant.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
    end
    else if (run)
    begin
      count <= count + 1'b1;
    end
    else
    begin
      count <= '0;
    end
  end

  assign timesUp = (count == limit);

endmodule

`default_nettype wire

/* design/portArbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module portArbiter
  import nocPkg::*;
(
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic [NUM_PORTS-1:0] req,
  input  wire flitT [NUM_PORTS-1:0] inFlit,
  output grantT                     grant
);

  logic [NUM_PORTS-1:0] run;
  logic [NUM_PORTS-1:0] timesUp;

  grantT   nextGrant;
  portIdxT holder;
  logic    holdValid;
  logic    keepGrant;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Per-port packet timers.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar p = int'(PORT_L); p <= int'(PORT_S); p++)
  begin : genTimer
    packetTimer timer (
      .clk     (clk),
      .rst     (rst),
      .inFlit  (inFlit[p]),
      .run     (run[p]),
      .timesUp (timesUp[p])
    );
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Rotating priority search.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Scan the five ports starting at first. The scan runs backwards so the
  // candidate closest to first is the one left standing.
  function automatic grantT pickFrom(
    input portIdxT              first,
    input logic [NUM_PORTS-1:0] reqs
  );
    int    idx;
    grantT pick;
    pick = GRANT_IDLE;
    for (int k = NUM_PORTS - 1; k >= 0; k--)
    begin
      idx = (int'(first) + k) % NUM_PORTS;
      if (reqs[idx])
      begin
        pick = portGrant(portIdxT'(idx));
      end
    end
    return pick;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Next-state logic.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Find which port, if any, owns the current one-hot state.
  always_comb
  begin
    holdValid = 1'b0;
    holder = PORT_L;
    for (int p = int'(PORT_L); p <= int'(PORT_S); p++)
    begin
      if (grant == portGrant(portIdxT'(p)))
      begin
        holdValid = 1'b1;
        holder = portIdxT'(p);
      end
    end
  end

  // The holder keeps the output while it asks and its time is not spent.
  assign keepGrant = holdValid && req[holder] && !timesUp[holder];

  always_comb
  begin
    run = '0;
    if (grant == GRANT_IDLE)
    begin
      // Fixed order L, N, E, W, S from idle.
      nextGrant = pickFrom(PORT_L, req);
    end
    else if (!holdValid)
    begin
      // Not one-hot, so fall back to idle.
      nextGrant = GRANT_IDLE;
    end
    else if (keepGrant)
    begin
      run[holder] = 1'b1;
      nextGrant = grant;
    end
    else
    begin
      // The holder itself is the last port in the scan, so a lone requester
      // is granted again without passing through idle.
      nextGrant = pickFrom(nextPort(holder), req);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // State register.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant <= GRANT_IDLE;
    end
    else
    begin
      grant <= nextGrant;
    end
  end

endmodule

`default_nettype wire

/* design/outputMux.sv */
`timescale 1ns/1ps
`default_nettype none

module outputMux
  import nocPkg::*;
#(
  parameter int DATA_W = 32
)
(
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire grantT                grant,
  input  wire flitT [NUM_PORTS-1:0] inFlit,
  output flitT                      outFlit,
  output logic                      outValid
);

  localparam logic [DATA_W-1:0] ZERO_DATA = '0;

  flitT selFlit;
  logic selValid;

  // One-hot select. Idle, or a state with no port bit, yields the zero flit.
  always_comb
  begin
    selFlit.kind = FLIT_IDLE;
    selFlit.length = '0;
    selFlit.data = ZERO_DATA;
    selValid = 1'b0;
    for (int p = int'(PORT_L); p <= int'(PORT_S); p++)
    begin
      if (grant[p + 1])
      begin
        selFlit = inFlit[p];
        selValid = 1'b1;
      end
    end
  end

  // Output stage, one cycle behind the grant.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outFlit <= '0;
      outValid <= 1'b0;
    end
    else
    begin
      outFlit <= selFlit;
      outValid <= selValid;
    end
  end

endmodule

`default_nettype wire

/* design/routerOutputPort.sv */
`timescale 1ns/1ps
`default_nettype none

module routerOutputPort
  import nocPkg::*;
#(
  parameter int DATA_W = 32
)
(
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic [NUM_PORTS-1:0] req,
  input  wire flitT [NUM_PORTS-1:0] inFlit,
  output grantT                     grant,
  output flitT                      outFlit,
  output logic                      outValid
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Arbitration. The grant is also a top-level output.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  portArbiter arbiter (
    .clk    (clk),
    .rst    (rst),
    .req    (req),
    .inFlit (inFlit),
    .grant  (grant)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Flit forwarding.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  outputMux #(
    .DATA_W (DATA_W)
  ) mux (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .inFlit   (inFlit),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

endmodule

`default_nettype wire

/* bench/routerOutputPortTb.sv */
`timescale 1ns/1ps
`default_nettype none

module routerOutputPortTb
  import nocPkg::*;
();

  localparam int NUM_TESTS = 5;
  localparam int MAX_STEPS = 20;
  localparam int SETTLE_LIMIT = 10;
  localparam int RUN_LIMIT = 2000;

  localparam grantT G_L = 6'b00_0010;
  localparam grantT G_N = 6'b00_0100;
  localparam grantT G_E = 6'b00_1000;
  localparam grantT G_W = 6'b01_0000;
  localparam grantT G_S = 6'b10_0000;

  localparam logic [NUM_PORTS-1:0] R_N = 5'b0_0010;
  localparam logic [NUM_PORTS-1:0] R_E = 5'b0_0100;
  localparam logic [NUM_PORTS-1:0] R_W = 5'b0_1000;
  localparam logic [NUM_PORTS-1:0] R_S = 5'b1_0000;
  localparam logic [NUM_PORTS-1:0] R_ALL = 5'b1_1111;

  logic                 clk;
  logic                 rst;
  logic [NUM_PORTS-1:0] req;
  flitT [NUM_PORTS-1:0] inFlit;
  grantT                grant;
  flitT                 outFlit;
  logic                 outValid;

  // Stimulus table. Entry i of expSeq is the grant that follows sampling reqSeq entry i.
  string                testName [NUM_TESTS];
  int                   testSteps [NUM_TESTS];
  logic [NUM_PORTS-1:0] reqSeq [NUM_TESTS][MAX_STEPS];
  grantT                expSeq [NUM_TESTS][MAX_STEPS];
  logic [LEN_W-1:0]     headLen [NUM_TESTS][NUM_PORTS];

  flitT [NUM_PORTS-1:0] curFlits;
  flitT [NUM_PORTS-1:0] prevFlits;
  int   seed = 32'h4d97_8c7b;
  int   stepCount;
  int   checks;
  int   errors;
  int   totalChecks;
  int   totalErrors;
  int   testsRun;
  int   testsFailed;
  logic timedOut;

  always #4 clk = ~clk;

  routerOutputPort #(
    .DATA_W (32)
  ) UUT (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .inFlit   (inFlit),
    .grant    (grant),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Table setup.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic setSteps(input int t, input int first, input int count,
                          input logic [NUM_PORTS-1:0] reqs, input grantT exp);
    for (int i = first; i < first + count; i++)
    begin
      reqSeq[t][i] = reqs;
      expSeq[t][i] = exp;
    end
  endtask

  task automatic fillTable();
    for (int t = 0; t < NUM_TESTS; t++)
    begin
      for (int p = 0; p < NUM_PORTS; p++)
      begin
        headLen[t][p] = '0;
      end
    end
    testName[0] = "singleEast";
    testSteps[0] = 4;
    headLen[0][PORT_E] = 12'd6;
    setSteps(0, 0, 4, R_E, G_E);
    testName[1] = "fixedPriority";
    testSteps[1] = 2;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      headLen[1][p] = 12'd3;
      headLen[2][p] = 12'd2;
    end
    setSteps(1, 0, 2, R_ALL, G_L);
    // A limit of 2 holds each port for three cycles before the turn passes.
    testName[2] = "rotation";
    testSteps[2] = 18;
    setSteps(2, 0, 3, R_ALL, G_L);
    setSteps(2, 3, 3, R_ALL, G_N);
    setSteps(2, 6, 3, R_ALL, G_E);
    setSteps(2, 9, 3, R_ALL, G_W);
    setSteps(2, 12, 3, R_ALL, G_S);
    setSteps(2, 15, 3, R_ALL, G_L);
    // N lets go early, then comes back for a full 11 cycles from a fresh count.
    testName[3] = "earlyRelease";
    testSteps[3] = 17;
    headLen[3][PORT_N] = 12'd10;
    headLen[3][PORT_W] = 12'd1;
    setSteps(3, 0, 1, R_N, G_N);
    setSteps(3, 1, 1, R_N | R_W, G_N);
    setSteps(3, 2, 2, R_W, G_W);
    setSteps(3, 4, 11, R_N, G_N);
    setSteps(3, 15, 1, R_N | R_W, G_W);
    setSteps(3, 16, 1, R_W, G_W);
    testName[4] = "loneSouth";
    testSteps[4] = 5;
    setSteps(4, 0, 5, R_S, G_S);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Helpers.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic int grantedPort(input grantT g);
    int port;
    port = -1;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      if (g[p + 1])
      begin
        port = p;
      end
    end
    return port;
  endfunction

  // Top byte names the source port, the next byte is the step number.
  task automatic buildFlits(input int t, input logic isHead);
    flitT f;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      f.kind = isHead ? FLIT_HEAD : FLIT_BODY;
      f.length = isHead ? headLen[t][p] : '0;
      f.data = {8'(p), 8'(stepCount), 16'($random(seed))};
      curFlits[p] = f;
    end
  endtask

  task automatic compareOutputs(input grantT expGrant, input logic expValid,
                                input flitT expFlit);
    checks += 3;
    assert (grant === expGrant) else
    begin
      $display("CHECK FAILED at %0t ns: grant expected %b, got %b", $time, expGrant, grant);
      errors++;
    end
    assert (outValid === expValid) else
    begin
      $display("CHECK FAILED at %0t ns: outValid expected %b, got %b",
               $time, expValid, outValid);
      errors++;
    end
    assert (outFlit === expFlit) else
    begin
      $display("CHECK FAILED at %0t ns: outFlit expected %h, got %h", $time, expFlit, outFlit);
      errors++;
    end
  endtask

  task automatic waitIdle(output logic settled);
    int waited;
    settled = 1'b0;
    waited = 0;
    while (!settled && waited < SETTLE_LIMIT)
    begin
      @(posedge clk);
      req <= '0;
      inFlit <= '0;
      @(negedge clk);
      settled = (grant === GRANT_IDLE) && (outValid === 1'b0) && (outFlit === '0);
      waited++;
    end
  endtask

  // Two trailing steps let the last grant and its forwarded flit drain.
  task automatic runTest(input int t);
    int    n;
    int    port;
    grantT expGrant;
    grantT prevGrant;
    logic  expValid;
    flitT  expFlit;
    n = testSteps[t];
    prevGrant = GRANT_IDLE;
    for (int i = 0; i <= n + 1; i++)
    begin
      prevFlits = curFlits;
      @(posedge clk);
      buildFlits(t, i == 0);
      req <= (i < n) ? reqSeq[t][i] : '0;
      inFlit <= curFlits;
      stepCount++;
      @(negedge clk);
      expGrant = (i == 0 || i > n) ? GRANT_IDLE : expSeq[t][i - 1];
      port = grantedPort(prevGrant);
      expValid = (port >= 0);
      if (expValid)
      begin
        expFlit = prevFlits[port];
      end
      else
      begin
        expFlit = '0;
      end
      compareOutputs(expGrant, expValid, expFlit);
      prevGrant = expGrant;
    end
  endtask

  task automatic reportTest(input string name);
    $display("Test %-14s %0d checks, %0d errors", name, checks, errors);
    totalChecks += checks;
    totalErrors += errors;
    testsRun++;
    if (errors != 0)
    begin
      testsFailed++;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Main sequence.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial
  begin
    logic settled;
    clk = 1'b0;
    rst = 1'b1;
    req = '0;
    inFlit = '0;
    curFlits = '0;
    prevFlits = '0;
    stepCount = 0;
    totalChecks = 0;
    totalErrors = 0;
    testsRun = 0;
    testsFailed = 0;
    timedOut = 1'b0;
    fillTable();

    // Requests and head flits are presented during reset, which must keep the
    // outputs idle. They are withdrawn on the edge that releases reset, and the
    // last check falls one cycle after the release.
    checks = 0;
    errors = 0;
    for (int c = 0; c < 9; c++)
    begin
      @(posedge clk);
      if (c == 0)
      begin
        buildFlits(0, 1'b1);
        req <= R_ALL;
        inFlit <= curFlits;
      end
      else if (c == 7)
      begin
        rst <= 1'b0;
        req <= '0;
        inFlit <= '0;
      end
      @(negedge clk);
      compareOutputs(GRANT_IDLE, 1'b0, '0);
    end
    reportTest("resetState");

    for (int t = 0; t < NUM_TESTS && !timedOut; t++)
    begin
      checks = 0;
      errors = 0;
      waitIdle(settled);
      if (!settled)
      begin
        $display("Timeout: outputs did not return to idle before test %s", testName[t]);
        errors++;
        timedOut = 1'b1;
      end
      else
      begin
        runTest(t);
      end
      reportTest(testName[t]);
    end

    $display("Summary: %0d tests run, %0d failed, %0d checks, %0d errors",
             testsRun, testsFailed, totalChecks, totalErrors);
    if (totalErrors == 0)
    begin
      $display("PASS: all tests");
    end
    else
    begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial
  begin
    repeat (RUN_LIMIT) @(posedge clk);
    $display("Timeout: simulation ran past %0d cycles", RUN_LIMIT);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
design/nocPkg.sv
design/packetTimer.sv
design/portArbiter.sv
design/outputMux.sv
design/routerOutputPort.sv
bench/routerOutputPortTb.sv
